/* rtl/daq_defines.svh */
// FIFO depths, pointer width, register addresses and control bit position
`ifndef DAQ_DEFINES_SVH
`define DAQ_DEFINES_SVH

// One slot stays free so a channel FIFO holds 7 hits
`define DAQ_CH_FIFO_DEPTH 8

// Output FIFO holds 15 merged words
`define DAQ_OUT_FIFO_DEPTH 16

// Width of pointers and fill levels
`define DAQ_PTR_W 5

// Register map of the host slave
`define DAQ_ADDR_CTRL 32'h0000_0000
`define DAQ_ADDR_STATUS 32'h0000_0004
`define DAQ_ADDR_DATA 32'h0000_0008
`define DAQ_ADDR_LOST 32'h0000_000C

// Drain enable in the control register
`define DAQ_CTRL_DRAIN_BIT 0

`endif

/* rtl/daq_pkg.sv */
// Hit word, merged output word and AXI response types
package daq_pkg;

    // Raw hit from one front-end channel
    typedef struct packed {
        logic [8:0] row;
        logic [5:0] col;
        logic [3:0] tot;  // Time over threshold
        logic [4:0] ts;   // Coarse timestamp
    } hit_t;

    // Word pushed into the output FIFO and read by the host
    typedef struct packed {
        logic       ch;   // Source channel
        logic [6:0] seq;  // Running merge count
        hit_t       hit;
    } word_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

/* rtl/fifo_rd_if.sv */
// Read side of a FIFO with source and sink modports
`include "daq_defines.svh"

interface fifo_rd_if #(
    parameter type payload_t = logic [31:0]
);

    logic                  read;   // Pop request from the consumer
    logic                  empty;
    payload_t              data;   // Registered head word
    logic [`DAQ_PTR_W-1:0] size;   // Fill level

    modport source (
        input  read,
        output empty,
        output data,
        output size
    );

    modport sink (
        output read,
        input  empty,
        input  data,
        input  size
    );

endinterface

/* rtl/hit_fifo.sv */
// Circular-buffer FIFO with registered head word, fill level and overflow pulse
`include "daq_defines.svh"

module hit_fifo #(
    parameter int  DEPTH     = `DAQ_CH_FIFO_DEPTH,
    parameter type payload_t = daq_pkg::hit_t
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      write,
    input  payload_t  data_in,
    output logic      full,
    output logic      overflow,
    fifo_rd_if.source rd
);

    localparam int PW = `DAQ_PTR_W;
    localparam int AW = $clog2(DEPTH);
    localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW-1:0] wr_next;
    logic [PW-1:0] rd_next;  // Look-ahead read address
    logic          push;
    logic          pop;

    assign push = write && !full;
    assign pop  = rd.read && !rd.empty;

    assign wr_next = (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
    assign full    = (wr_next == rd_ptr);  // One slot kept free

    always_comb begin
        rd_next = rd_ptr;
        if (pop) begin
            rd_next = (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_next;
            end
            rd_ptr <= rd_next;
        end
    end

    // Empty follows the pointers one edge late so it matches the head register
    always_ff @(posedge clk) begin
        if (reset) begin
            rd.empty <= 1'b1;
        end else begin
            rd.empty <= (wr_ptr == rd_next);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            overflow <= 1'b0;
        end else begin
            overflow <= write && full;  // Hit dropped
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= data_in;
        end
        rd.data <= mem[rd_next[AW-1:0]];
    end

    always_comb begin
        if (wr_ptr >= rd_ptr) begin
            rd.size = wr_ptr - rd_ptr;
        end else begin
            rd.size = wr_ptr + (PW'(DEPTH) - rd_ptr);  // Write pointer has wrapped
        end
    end

    // Full means the write pointer sits one slot behind the read pointer
    a_no_pass_when_full: assert property (@(posedge clk) disable iff (reset)
        full |-> rd.size == LAST);

    a_not_empty_and_full: assert property (@(posedge clk) disable iff (reset)
        !(rd.empty && full));

endmodule

/* rtl/hit_merger.sv */
// Round-robin merge of two channel FIFOs into tagged output words
module hit_merger (
    input  logic           clk,
    input  logic           reset,
    input  logic           drain,
    fifo_rd_if.sink        ch0,
    fifo_rd_if.sink        ch1,
    input  logic           out_full,
    output logic           out_write,
    output daq_pkg::word_t out_data
);

    import daq_pkg::*;

    logic       rr_ptr;  // Channel preferred when both have data
    logic       sel;
    logic       go;
    logic [6:0] seq;
    hit_t       head;

    always_comb begin
        if (ch0.empty) begin
            sel = 1'b1;
        end else if (ch1.empty) begin
            sel = 1'b0;
        end else begin
            sel = rr_ptr;
        end
    end

    // Stall on a full output FIFO and let the channel FIFOs absorb hits
    assign go = drain && !out_full && !(ch0.empty && ch1.empty);

    assign ch0.read = go && !sel;
    assign ch1.read = go && sel;

    assign head      = sel ? ch1.data : ch0.data;
    assign out_write = go;
    assign out_data  = '{ch: sel, seq: seq, hit: head};

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= 1'b0;
            seq    <= '0;
        end else if (go) begin
            rr_ptr <= !sel;        // Other channel next time
            seq    <= seq + 1'b1;  // Wraps at 128
        end
    end

    a_single_pop: assert property (@(posedge clk) disable iff (reset)
        !(ch0.read && ch1.read));

endmodule

/* rtl/axil_regs.sv */
// AXI4-Lite slave with control, status, data-pop and lost-counter registers
`include "daq_defines.svh"

module axil_regs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output daq_pkg::axi_resp_t    bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [31:0]           araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output daq_pkg::axi_resp_t    rresp,
    output logic                  rvalid,
    input  logic                  rready,
    fifo_rd_if.sink               out,
    input  logic [`DAQ_PTR_W-1:0] ch0_size,
    input  logic [`DAQ_PTR_W-1:0] ch1_size,
    input  logic                  overflow0,
    input  logic                  overflow1,
    output logic                  drain
);

    import daq_pkg::*;

    logic        wr_start;
    logic        lost_clear;
    logic [31:0] lost_cnt;
    logic [31:0] ctrl_word;
    logic [31:0] status_word;

    // Address and data are taken together in one cycle
    assign wr_start = awvalid && wvalid && !awready && !bvalid;

    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= wr_start;
            wready  <= wr_start;
            if (awready) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awready) begin
            case (awaddr)
                `DAQ_ADDR_CTRL, `DAQ_ADDR_STATUS, `DAQ_ADDR_DATA, `DAQ_ADDR_LOST: begin
                    bresp <= OKAY;  // Read-only registers ignore the data
                end
                default: bresp <= SLVERR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            drain <= 1'b0;
        end else if (awready && awaddr == `DAQ_ADDR_CTRL) begin
            drain <= wdata[`DAQ_CTRL_DRAIN_BIT];
        end
    end

    assign lost_clear = awready && (awaddr == `DAQ_ADDR_LOST);

    // Both channels may drop a hit in the same cycle
    always_ff @(posedge clk) begin
        if (reset || lost_clear) begin
            lost_cnt <= '0;
        end else begin
            lost_cnt <= lost_cnt + 32'(overflow0) + 32'(overflow1);
        end
    end

    always_comb begin
        ctrl_word                      = '0;
        ctrl_word[`DAQ_CTRL_DRAIN_BIT] = drain;
    end

    always_comb begin
        status_word                       = '0;
        status_word[0 +: `DAQ_PTR_W]      = out.size;
        status_word[8 +: `DAQ_PTR_W]      = ch0_size;
        status_word[16 +: `DAQ_PTR_W]     = ch1_size;
        status_word[24]                   = out.empty;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Head word is captured on the same edge that pops it
    assign out.read = arready && (araddr == `DAQ_ADDR_DATA);

    always_ff @(posedge clk) begin
        if (arready) begin
            rresp <= OKAY;
            case (araddr)
                `DAQ_ADDR_CTRL:   rdata <= ctrl_word;
                `DAQ_ADDR_STATUS: rdata <= status_word;
                `DAQ_ADDR_DATA: begin
                    if (out.empty) begin
                        rdata <= '0;
                        rresp <= SLVERR;
                    end else begin
                        rdata <= out.data;
                    end
                end
                `DAQ_ADDR_LOST:   rdata <= lost_cnt;
                default: begin
                    rdata <= '0;
                    rresp <= SLVERR;
                end
            endcase
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* rtl/daq_readout.sv */
// Readout top with two channel FIFOs, merger, output FIFO and host register slave
`include "daq_defines.svh"

module daq_readout (
    input  logic               clk,
    input  logic               reset,
    input  logic               hit0_valid,
    input  daq_pkg::hit_t      hit0_data,
    input  logic               hit1_valid,
    input  daq_pkg::hit_t      hit1_data,
    input  logic [31:0]        awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  logic [31:0]        wdata,
    input  logic [3:0]         wstrb,
    input  logic               wvalid,
    output logic               wready,
    output daq_pkg::axi_resp_t bresp,
    output logic               bvalid,
    input  logic               bready,
    input  logic [31:0]        araddr,
    input  logic               arvalid,
    output logic               arready,
    output logic [31:0]        rdata,
    output daq_pkg::axi_resp_t rresp,
    output logic               rvalid,
    input  logic               rready
);

    import daq_pkg::*;

    fifo_rd_if #(.payload_t(hit_t))  ch0_rd ();
    fifo_rd_if #(.payload_t(hit_t))  ch1_rd ();
    fifo_rd_if #(.payload_t(word_t)) out_rd ();

    logic  overflow0;
    logic  overflow1;
    logic  out_full;
    logic  out_write;
    logic  drain;
    word_t out_data;

    // Front-end channels have no back-pressure so full only shows as overflow
    hit_fifo #(.DEPTH(`DAQ_CH_FIFO_DEPTH), .payload_t(hit_t)) u_ch0_fifo (
        .clk      (clk),
        .reset    (reset),
        .write    (hit0_valid),
        .data_in  (hit0_data),
        .full     (),
        .overflow (overflow0),
        .rd       (ch0_rd)
    );

    hit_fifo #(.DEPTH(`DAQ_CH_FIFO_DEPTH), .payload_t(hit_t)) u_ch1_fifo (
        .clk      (clk),
        .reset    (reset),
        .write    (hit1_valid),
        .data_in  (hit1_data),
        .full     (),
        .overflow (overflow1),
        .rd       (ch1_rd)
    );

    hit_merger u_merger (
        .clk       (clk),
        .reset     (reset),
        .drain     (drain),
        .ch0       (ch0_rd),
        .ch1       (ch1_rd),
        .out_full  (out_full),
        .out_write (out_write),
        .out_data  (out_data)
    );

    // Merger never writes while full
    hit_fifo #(.DEPTH(`DAQ_OUT_FIFO_DEPTH), .payload_t(word_t)) u_out_fifo (
        .clk      (clk),
        .reset    (reset),
        .write    (out_write),
        .data_in  (out_data),
        .full     (out_full),
        .overflow (),
        .rd       (out_rd)
    );

    axil_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .out       (out_rd),
        .ch0_size  (ch0_rd.size),
        .ch1_size  (ch1_rd.size),
        .overflow0 (overflow0),
        .overflow1 (overflow1),
        .drain     (drain)
    );

endmodule

/* tb/tb_daq_readout.sv */
// Directed testbench with AXI4-Lite master tasks, hit drivers, reference queues and checks
`include "daq_defines.svh"

module tb_daq_readout;

    import daq_pkg::*;

    localparam int WAIT_MAX = 400;                     // Limit for every wait loop
    localparam int CH_CAP   = `DAQ_CH_FIFO_DEPTH - 1;  // One slot stays free

    logic        clk;
    logic        reset;
    logic        hit0_valid;
    hit_t        hit0_data;
    logic        hit1_valid;
    hit_t        hit1_data;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    axi_resp_t   bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    axi_resp_t   rresp;
    logic        rvalid;
    logic        rready;

    int          errors;
    int          timeouts;
    logic [31:0] lcg_state;
    logic [6:0]  exp_seq;    // Next sequence number the merger hands out
    hit_t        exp_q0[$];  // Channel 0 hits in the order sent
    hit_t        exp_q1[$];

    daq_readout i_dut (.*);

    always #20 clk = !clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic hit_t rand_hit();
        logic [31:0] r;
        r = lcg_next();
        return hit_t'(r[31:8]);  // Upper bits have the longer period
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s: got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("Timeout while waiting for %s at time %0t", what, $time);
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output axi_resp_t resp);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready) && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!(awready && wready)) timed_out("awready and wready");
        @(negedge clk);  // Handshake edge has passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) timed_out("bvalid");
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output axi_resp_t resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!arready) timed_out("arready");
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid) timed_out("rvalid");
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // One clock of hit traffic on either or both channels
    task automatic send_hits(input logic v0, input hit_t h0, input logic v1, input hit_t h1);
        hit0_valid = v0;
        hit0_data  = h0;
        hit1_valid = v1;
        hit1_data  = h1;
        if (v0) exp_q0.push_back(h0);
        if (v1) exp_q1.push_back(h1);
        @(negedge clk);
        hit0_valid = 1'b0;
        hit1_valid = 1'b0;
    endtask

    task automatic wait_out_level(input int level);
        logic [31:0] st;
        axi_resp_t   resp;
        int          n;
        n  = 0;
        st = '0;
        while (int'(st[4:0]) != level && n < WAIT_MAX) begin
            axi_read(`DAQ_ADDR_STATUS, st, resp);
            n++;
        end
        if (int'(st[4:0]) != level) timed_out("output FIFO fill level");
    endtask

    // Pops one word and compares it with the channel's oldest pending hit
    task automatic read_word(output word_t w);
        logic [31:0] d;
        axi_resp_t   resp;
        hit_t        exp_hit;
        axi_read(`DAQ_ADDR_DATA, d, resp);
        w = word_t'(d);
        check(32'(resp), 32'(OKAY), "DATA read response");
        check(32'(w.seq), 32'(exp_seq), "sequence number");
        exp_seq = exp_seq + 7'd1;
        if ((w.ch && exp_q1.size() == 0) || (!w.ch && exp_q0.size() == 0)) begin
            errors++;
            $display("** Error at %0t: word from channel %0d with no hit pending", $time, w.ch);
        end else begin
            if (w.ch) begin
                exp_hit = exp_q1.pop_front();
            end else begin
                exp_hit = exp_q0.pop_front();
            end
            check(32'(w.hit), 32'(exp_hit), "hit fields");
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] d;
        axi_resp_t   resp;
        axi_read(`DAQ_ADDR_STATUS, d, resp);
        check(d, 32'h0100_0000, "STATUS after reset");  // Only output-empty set
        axi_read(`DAQ_ADDR_CTRL, d, resp);
        check(d, 32'h0, "CTRL after reset");
        axi_read(`DAQ_ADDR_LOST, d, resp);
        check(d, 32'h0, "LOST after reset");
        axi_read(`DAQ_ADDR_DATA, d, resp);
        check(d, 32'h0, "DATA from empty FIFO");
        check(32'(resp), 32'(SLVERR), "DATA response on empty FIFO");
    endtask

    task automatic test_single_hits();
        word_t     w;
        hit_t      h0;
        hit_t      h1;
        axi_resp_t resp;
        axi_write(`DAQ_ADDR_CTRL, 32'h1, resp);
        h0 = rand_hit();
        h1 = rand_hit();
        send_hits(1'b1, h0, 1'b0, '0);
        repeat (6) @(negedge clk);  // Gap so channel 0 merges first
        send_hits(1'b0, '0, 1'b1, h1);
        wait_out_level(2);
        read_word(w);
        check(32'(w), {1'b0, 7'd0, h0}, "first single-hit word");
        read_word(w);
        check(32'(w), {1'b1, 7'd1, h1}, "second single-hit word");
    endtask

    task automatic test_bursts();
        word_t w;
        for (int i = 0; i < 6; i++) begin
            send_hits(1'b1, rand_hit(), 1'b1, rand_hit());
        end
        wait_out_level(12);
        for (int i = 0; i < 12; i++) begin
            read_word(w);
        end
        check(32'(exp_q0.size() + exp_q1.size()), 32'h0, "hits left after burst");
    endtask

    task automatic test_overflow();
        logic [31:0] d;
        axi_resp_t   resp;
        word_t       w;
        axi_write(`DAQ_ADDR_CTRL, 32'h0, resp);
        axi_write(`DAQ_ADDR_LOST, 32'h0, resp);
        for (int i = 0; i < 10; i++) begin
            send_hits(1'b1, rand_hit(), 1'b0, '0);
        end
        while (exp_q0.size() > CH_CAP) begin
            exp_q0.delete(exp_q0.size() - 1);  // Arrived while the channel FIFO was full
        end
        axi_read(`DAQ_ADDR_STATUS, d, resp);
        check(d, 32'h0100_0000 | (32'(CH_CAP) << 8), "STATUS with channel 0 full");
        axi_read(`DAQ_ADDR_LOST, d, resp);
        check(d, 32'(10 - CH_CAP), "LOST after overflow");
        axi_write(`DAQ_ADDR_LOST, 32'h0, resp);
        axi_read(`DAQ_ADDR_LOST, d, resp);
        check(d, 32'h0, "LOST after clear");
        axi_write(`DAQ_ADDR_CTRL, 32'h1, resp);
        wait_out_level(CH_CAP);
        for (int i = 0; i < CH_CAP; i++) begin
            read_word(w);
        end
    endtask

    task automatic test_register_map();
        logic [31:0] d;
        axi_resp_t   resp;
        axi_write(`DAQ_ADDR_CTRL, 32'h1, resp);
        check(32'(resp), 32'(OKAY), "CTRL write response");
        axi_read(`DAQ_ADDR_CTRL, d, resp);
        check(d, 32'h1, "CTRL readback of 1");
        axi_write(`DAQ_ADDR_CTRL, 32'h0, resp);
        axi_read(`DAQ_ADDR_CTRL, d, resp);
        check(d, 32'h0, "CTRL readback of 0");
        axi_read(32'h10, d, resp);
        check(32'(resp), 32'(SLVERR), "unmapped read response");
        axi_write(32'h10, 32'hFFFF_FFFF, resp);  // Bit 0 set would wrongly enable drain
        check(32'(resp), 32'(SLVERR), "unmapped write response");
        axi_read(`DAQ_ADDR_CTRL, d, resp);
        check(d, 32'h0, "CTRL after unmapped write");
        axi_read(`DAQ_ADDR_STATUS, d, resp);
        check(d, 32'h0100_0000, "STATUS after unmapped write");
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        hit0_valid = 1'b0;
        hit0_data  = '0;
        hit1_valid = 1'b0;
        hit1_data  = '0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = 4'hF;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        errors     = 0;
        timeouts   = 0;
        exp_seq    = '0;
        lcg_state  = 32'h5e14_9b63;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_single_hits();
        test_bursts();
        test_overflow();
        test_register_map();
        $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/daq_pkg.sv
rtl/fifo_rd_if.sv
rtl/hit_fifo.sv
rtl/hit_merger.sv
rtl/axil_regs.sv
rtl/daq_readout.sv
tb/tb_daq_readout.sv

/* run_sim.sh */
#!/bin/sh
# Build the readout buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_daq_readout

./obj_dir/Vtb_daq_readout | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "Result: PASS"
else
    echo "Result: FAIL"
    exit 1
fi
